/* design/gpr_alu_settings.svh */
`ifndef GPR_ALU_SETTINGS_SVH
`define GPR_ALU_SETTINGS_SVH

// datapath width, fixed by the x86 register model
`define WORD_WIDTH 32

// eight general purpose registers, each split into four byte lanes
`define GPR_COUNT 8
`define LANE_COUNT 4

// access size codes, shared by the read and write ports
`define SIZE_BYTE_LO 2'd0
// second byte, as with AH
`define SIZE_BYTE_HI 2'd1
`define SIZE_HALF 2'd2
`define SIZE_WORD 2'd3

// ALU opcodes
`define OP_ADD 3'd0
`define OP_OR 3'd1
`define OP_NOT 3'd2
`define OP_DAA 3'd3
`define OP_AND 3'd4
`define OP_CLD 3'd5
// sub computes b minus a
`define OP_SUB 3'd6
`define OP_STD 3'd7

// flag bit positions in the EFLAGS-style word
`define FLAG_CF 0
`define FLAG_PF 2
`define FLAG_AF 4
`define FLAG_ZF 6
`define FLAG_SF 7
`define FLAG_DF 10
`define FLAG_OF 11

`endif

/* design/gpr_pkg.sv */
`default_nettype none

`include "gpr_alu_settings.svh"

package gpr_pkg;

    // one data word as held in a general purpose register
    typedef logic [`WORD_WIDTH-1:0] word_t;

    // register number, EAX is 0 through EDI at 7
    typedef logic [$clog2(`GPR_COUNT)-1:0] gpr_idx_t;

    // size code of a read or write access, see the SIZE_ macros
    typedef logic [1:0] access_size_t;

    // one write enable per byte lane
    // bit 0 is ll, bit 1 is lh, bit 2 is hl and bit 3 is hh
    typedef logic [`LANE_COUNT-1:0] lane_mask_t;

endpackage

`default_nettype wire

/* design/alu_pkg.sv */
`default_nettype none

`include "gpr_alu_settings.svh"

package alu_pkg;

    // opcode selecting one of the eight ALU operations
    typedef logic [2:0] alu_op_t;

    // flags word, laid out as the low part of EFLAGS
    // only CF, PF, AF, ZF, SF, DF and OF are ever written
    typedef logic [`WORD_WIDTH-1:0] flags_t;

endpackage

`default_nettype wire

/* design/gpr_write_port.sv */
`default_nettype none
`timescale 1ns/1ps

`include "gpr_alu_settings.svh"

module gpr_write_port (
    input  logic                                 enable,
    input  gpr_pkg::gpr_idx_t                    dst,
    input  gpr_pkg::access_size_t                size,
    input  gpr_pkg::word_t                       data,
    output gpr_pkg::lane_mask_t [`GPR_COUNT-1:0] reg_lanes,
    output gpr_pkg::word_t                       lane_data
);
    import gpr_pkg::*;

    // lanes touched by the access size, before the register is chosen
    lane_mask_t size_lanes;

    always_comb begin
        case (size)
            `SIZE_BYTE_LO: size_lanes = 4'b0001;
            `SIZE_BYTE_HI: size_lanes = 4'b0010;
            `SIZE_HALF:    size_lanes = 4'b0011;
            default:       size_lanes = 4'b1111;
        endcase
    end

    // only the destination register sees the lane enables
    // and nothing is enabled while the request strobe is low
    always_comb begin
        for (int r = 0; r < `GPR_COUNT; r++) begin
            if (enable && (dst == gpr_idx_t'(r))) begin
                reg_lanes[r] = size_lanes;
            end else begin
                reg_lanes[r] = '0;
            end
        end
    end

    // a high byte write takes its byte from data bits 7..0,
    // so the byte is copied up into lane lh
    // the bank only looks at the enabled lanes, the rest pass as they are
    assign lane_data = (size == `SIZE_BYTE_HI) ? {data[31:16], data[7:0], data[7:0]} : data;

endmodule

`default_nettype wire

/* design/gpr_bank.sv */
`default_nettype none
`timescale 1ns/1ps

`include "gpr_alu_settings.svh"

module gpr_bank (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  gpr_pkg::lane_mask_t [`GPR_COUNT-1:0] load_lanes,
    input  gpr_pkg::lane_mask_t [`GPR_COUNT-1:0] alu_lanes,
    input  gpr_pkg::word_t                       load_lane_data,
    input  gpr_pkg::word_t                       alu_lane_data,
    output gpr_pkg::word_t [`GPR_COUNT-1:0]      regs
);
    import gpr_pkg::*;

    // register contents after this cycle's writes
    word_t [`GPR_COUNT-1:0] regs_next;

    // each byte lane of each register is written on its own
    // the ALU write-back wins over the external load on the same lane,
    // lanes not enabled by either port keep their value
    always_comb begin
        regs_next = regs;
        for (int r = 0; r < `GPR_COUNT; r++) begin
            for (int l = 0; l < `LANE_COUNT; l++) begin
                if (alu_lanes[r][l]) begin
                    regs_next[r][8*l +: 8] = alu_lane_data[8*l +: 8];
                end else if (load_lanes[r][l]) begin
                    regs_next[r][8*l +: 8] = load_lane_data[8*l +: 8];
                end
            end
        end
    end

    // all registers come out of reset as zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else begin
            regs <= regs_next;
        end
    end

endmodule

`default_nettype wire

/* design/gpr_read_port.sv */
`default_nettype none
`timescale 1ns/1ps

`include "gpr_alu_settings.svh"

module gpr_read_port (
    input  gpr_pkg::word_t [`GPR_COUNT-1:0] regs,
    input  gpr_pkg::gpr_idx_t               sel,
    input  gpr_pkg::access_size_t           size,
    output gpr_pkg::word_t                  data
);
    import gpr_pkg::*;

    // full contents of the selected register
    word_t sel_word;

    assign sel_word = regs[sel];

    // bits outside the access size read as zero
    always_comb begin
        case (size)
            `SIZE_BYTE_LO: begin
                data = {24'b0, sel_word[7:0]};
            end
            // the second byte comes back in the low byte, as AH would
            `SIZE_BYTE_HI: begin
                data = {24'b0, sel_word[15:8]};
            end
            `SIZE_HALF: begin
                data = {16'b0, sel_word[15:0]};
            end
            default: begin
                data = sel_word;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/alu32.sv */
`default_nettype none
`timescale 1ns/1ps

`include "gpr_alu_settings.svh"

module alu32 (
    input  logic            exec,
    input  alu_pkg::alu_op_t op,
    input  gpr_pkg::word_t  a,
    input  gpr_pkg::word_t  b,
    input  alu_pkg::flags_t flags,
    output gpr_pkg::word_t  result,
    output logic            result_write,
    output alu_pkg::flags_t flags_next,
    output alu_pkg::flags_t flags_update
);
    import gpr_pkg::*;
    import alu_pkg::*;

    word_t       a_inv;
    logic [32:0] add_sum;
    logic [32:0] sub_sum;
    logic [4:0]  add_nib;
    logic [4:0]  sub_nib;
    logic        daa_low_adj;
    logic        daa_high_adj;
    logic [7:0]  daa_byte;
    // bits of the flags word that the current op defines
    flags_t      op_mask;
    // ops whose ZF, SF and PF follow the result
    logic        sets_result_flags;

    assign a_inv = ~a;

    // add, with the carries out of bit 31 and bit 3 kept for CF and AF
    assign add_sum = {1'b0, a} + {1'b0, b};
    assign add_nib = {1'b0, a[3:0]} + {1'b0, b[3:0]};

    // sub is b plus inverted a plus one, so CF is set when b is at least a
    assign sub_sum = {1'b0, b} + {1'b0, a_inv} + 33'd1;
    assign sub_nib = {1'b0, b[3:0]} + {1'b0, a_inv[3:0]} + 5'd1;

    // decimal adjust of the low byte
    // both checks look at the original byte of a and the old AF and CF
    assign daa_low_adj  = (a[3:0] > 4'd9) || flags[`FLAG_AF];
    assign daa_high_adj = (a[7:0] > 8'h99) || flags[`FLAG_CF];
    assign daa_byte     = a[7:0] + (daa_low_adj ? 8'h06 : 8'h00)
                        + (daa_high_adj ? 8'h60 : 8'h00);

    always_comb begin
        result            = '0;
        flags_next        = flags;
        op_mask           = '0;
        sets_result_flags = 1'b0;
        case (op)
            `OP_ADD: begin
                result                 = add_sum[31:0];
                flags_next[`FLAG_CF]   = add_sum[32];
                flags_next[`FLAG_AF]   = add_nib[4];
                // operands agree in sign and the sum does not
                flags_next[`FLAG_OF]   = (a[31] == b[31]) && (add_sum[31] != a[31]);
                op_mask[`FLAG_CF]      = 1'b1;
                op_mask[`FLAG_AF]      = 1'b1;
                op_mask[`FLAG_OF]      = 1'b1;
                sets_result_flags      = 1'b1;
            end
            `OP_SUB: begin
                result                 = sub_sum[31:0];
                flags_next[`FLAG_CF]   = sub_sum[32];
                flags_next[`FLAG_AF]   = sub_nib[4];
                // the addends are b and inverted a, so overflow needs differing signs
                flags_next[`FLAG_OF]   = (b[31] != a[31]) && (sub_sum[31] != b[31]);
                op_mask[`FLAG_CF]      = 1'b1;
                op_mask[`FLAG_AF]      = 1'b1;
                op_mask[`FLAG_OF]      = 1'b1;
                sets_result_flags      = 1'b1;
            end
            `OP_OR, `OP_AND: begin
                result                 = (op == `OP_OR) ? (a | b) : (a & b);
                flags_next[`FLAG_CF]   = 1'b0;
                flags_next[`FLAG_OF]   = 1'b0;
                op_mask[`FLAG_CF]      = 1'b1;
                op_mask[`FLAG_OF]      = 1'b1;
                sets_result_flags      = 1'b1;
            end
            `OP_NOT: begin
                // no flag changes at all
                result = a_inv;
            end
            `OP_DAA: begin
                result                 = {a[31:8], daa_byte};
                flags_next[`FLAG_AF]   = daa_low_adj;
                flags_next[`FLAG_CF]   = daa_high_adj;
                op_mask[`FLAG_AF]      = 1'b1;
                op_mask[`FLAG_CF]      = 1'b1;
                sets_result_flags      = 1'b1;
            end
            `OP_CLD: begin
                flags_next[`FLAG_DF] = 1'b0;
                op_mask[`FLAG_DF]    = 1'b1;
            end
            default: begin
                // std
                flags_next[`FLAG_DF] = 1'b1;
                op_mask[`FLAG_DF]    = 1'b1;
            end
        endcase

        // PF is even parity of the low result byte only
        if (sets_result_flags) begin
            flags_next[`FLAG_ZF] = (result == '0);
            flags_next[`FLAG_SF] = result[31];
            flags_next[`FLAG_PF] = ~^result[7:0];
            op_mask[`FLAG_ZF]    = 1'b1;
            op_mask[`FLAG_SF]    = 1'b1;
            op_mask[`FLAG_PF]    = 1'b1;
        end
    end

    // cld and std touch only the flags, every other op writes back
    assign result_write = exec && (op != `OP_CLD) && (op != `OP_STD);
    assign flags_update = exec ? op_mask : '0;

endmodule

`default_nettype wire

/* design/flags_reg.sv */
`default_nettype none
`timescale 1ns/1ps

module flags_reg (
    input  logic            clk,
    input  logic            rst_n,
    input  alu_pkg::flags_t flags_next,
    input  alu_pkg::flags_t flags_update,
    output alu_pkg::flags_t flags
);
    import alu_pkg::*;

    // bits under the update mask take the new value, the rest hold
    flags_t flags_merged;

    assign flags_merged = (flags & ~flags_update) | (flags_next & flags_update);

    // a zero mask, as when exec is low, leaves the word unchanged
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags <= '0;
        end else begin
            flags <= flags_merged;
        end
    end

endmodule

`default_nettype wire

/* design/gpr_alu_datapath.sv */
`default_nettype none
`timescale 1ns/1ps

`include "gpr_alu_settings.svh"

module gpr_alu_datapath (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  gpr_pkg::gpr_idx_t     load_dst,
    input  gpr_pkg::access_size_t load_size,
    input  gpr_pkg::word_t        load_data,
    input  logic                  exec,
    input  alu_pkg::alu_op_t      op,
    input  gpr_pkg::gpr_idx_t     src_a,
    input  gpr_pkg::access_size_t size_a,
    input  gpr_pkg::gpr_idx_t     src_b,
    input  gpr_pkg::access_size_t size_b,
    input  gpr_pkg::gpr_idx_t     dst,
    input  gpr_pkg::access_size_t dst_size,
    input  gpr_pkg::gpr_idx_t     obs_sel,
    input  gpr_pkg::access_size_t obs_size,
    output gpr_pkg::word_t        obs_data,
    output alu_pkg::flags_t       flags
);
    import gpr_pkg::*;
    import alu_pkg::*;

    lane_mask_t [`GPR_COUNT-1:0] load_lanes;
    lane_mask_t [`GPR_COUNT-1:0] alu_lanes;
    word_t                       load_lane_data;
    word_t                       alu_lane_data;
    word_t [`GPR_COUNT-1:0]      regs;
    word_t                       opnd_a;
    word_t                       opnd_b;
    word_t                       alu_result;
    logic                        result_write;
    flags_t                      flags_next;
    flags_t                      flags_update;

    // external load request
    gpr_write_port load_port_i (
        .enable    (load),
        .dst       (load_dst),
        .size      (load_size),
        .data      (load_data),
        .reg_lanes (load_lanes),
        .lane_data (load_lane_data)
    );

    // ALU write-back request, raised only for ops that produce a result
    gpr_write_port alu_port_i (
        .enable    (result_write),
        .dst       (dst),
        .size      (dst_size),
        .data      (alu_result),
        .reg_lanes (alu_lanes),
        .lane_data (alu_lane_data)
    );

    gpr_bank bank_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .load_lanes     (load_lanes),
        .alu_lanes      (alu_lanes),
        .load_lane_data (load_lane_data),
        .alu_lane_data  (alu_lane_data),
        .regs           (regs)
    );

    // operand reads are combinational, same cycle as exec
    gpr_read_port read_a_i (
        .regs (regs),
        .sel  (src_a),
        .size (size_a),
        .data (opnd_a)
    );

    gpr_read_port read_b_i (
        .regs (regs),
        .sel  (src_b),
        .size (size_b),
        .data (opnd_b)
    );

    gpr_read_port read_obs_i (
        .regs (regs),
        .sel  (obs_sel),
        .size (obs_size),
        .data (obs_data)
    );

    alu32 alu_i (
        .exec         (exec),
        .op           (op),
        .a            (opnd_a),
        .b            (opnd_b),
        .flags        (flags),
        .result       (alu_result),
        .result_write (result_write),
        .flags_next   (flags_next),
        .flags_update (flags_update)
    );

    // the flags word feeds back into the ALU for daa and unchanged bits
    flags_reg flags_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flags_next   (flags_next),
        .flags_update (flags_update),
        .flags        (flags)
    );

endmodule

`default_nettype wire

/* bench/gpr_alu_checker.sv */
`default_nettype none
`timescale 1ns/1ps

`include "gpr_alu_settings.svh"

module gpr_alu_checker (
    input logic             clk,
    input logic             rst_n,
    input logic             exec,
    input alu_pkg::alu_op_t op,
    input alu_pkg::flags_t  flags,
    input gpr_pkg::word_t   obs_data
);

    // cld takes effect at the edge that samples it
    cld_clears_df: assert property (@(posedge clk) disable iff (!rst_n)
        (exec && (op == `OP_CLD)) |=> !flags[`FLAG_DF])
        else $error("cld left DF set");

    std_sets_df: assert property (@(posedge clk) disable iff (!rst_n)
        (exec && (op == `OP_STD)) |=> flags[`FLAG_DF])
        else $error("std left DF clear");

    // loads never touch the flags
    flags_hold_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !exec |=> $stable(flags))
        else $error("flags changed without exec");

    obs_data_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(obs_data))
        else $error("obs_data has unknown bits");

endmodule

bind gpr_alu_datapath gpr_alu_checker checker_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .exec     (exec),
    .op       (op),
    .flags    (flags),
    .obs_data (obs_data)
);

`default_nettype wire

/* bench/gpr_alu_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "gpr_alu_settings.svh"

module gpr_alu_tb;
    import gpr_pkg::*;
    import alu_pkg::*;

    logic         clk;
    logic         rst_n;
    logic         load;
    gpr_idx_t     load_dst;
    access_size_t load_size;
    word_t        load_data;
    logic         exec;
    alu_op_t      op;
    gpr_idx_t     src_a;
    access_size_t size_a;
    gpr_idx_t     src_b;
    access_size_t size_b;
    gpr_idx_t     dst;
    access_size_t dst_size;
    gpr_idx_t     obs_sel;
    access_size_t obs_size;
    word_t        obs_data;
    flags_t       flags;

    // expected register and flag contents, kept in step with the DUT
    word_t        model_regs [`GPR_COUNT];
    flags_t       model_flags;
    int           errors;
    int           seed;
    logic         edge_seen;

    gpr_alu_datapath gpr_alu_datapath_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .load_dst  (load_dst),
        .load_size (load_size),
        .load_data (load_data),
        .exec      (exec),
        .op        (op),
        .src_a     (src_a),
        .size_a    (size_a),
        .src_b     (src_b),
        .size_b    (size_b),
        .dst       (dst),
        .dst_size  (dst_size),
        .obs_sel   (obs_sel),
        .obs_size  (obs_size),
        .obs_data  (obs_data),
        .flags     (flags)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // each edge wait is guarded by its own 20 ns timer
    task automatic wait_falling_edges(input int count);
        int   seen;
        logic timed_out;
        seen      = 0;
        timed_out = 1'b0;
        while ((seen < count) && !timed_out) begin
            edge_seen = 1'b0;
            fork
                begin
                    @(negedge clk);
                    edge_seen = 1'b1;
                end
                #20;
            join_any
            disable fork;
            if (edge_seen) begin
                seen++;
            end else begin
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            $display("timeout: no falling clock edge came within 20 ns");
            $display("Something failed");
            $finish;
        end
    endtask

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s read %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic check_flags(input flags_t actual, input flags_t expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: flags are %h, expected %h", $time, actual, expected);
            errors++;
        end
    endtask

    // zero-extended read, the second byte comes back in the low byte
    function automatic word_t model_read(input gpr_idx_t sel, input access_size_t size);
        word_t w;
        w = model_regs[sel];
        case (size)
            `SIZE_BYTE_LO: return {24'h0, w[7:0]};
            `SIZE_BYTE_HI: return {24'h0, w[15:8]};
            `SIZE_HALF:    return {16'h0, w[15:0]};
            default:       return w;
        endcase
    endfunction

    task automatic model_write(input gpr_idx_t d, input access_size_t size, input word_t v);
        case (size)
            `SIZE_BYTE_LO: model_regs[d][7:0] = v[7:0];
            // AH style write, the byte is taken from bits 7..0
            `SIZE_BYTE_HI: model_regs[d][15:8] = v[7:0];
            `SIZE_HALF:    model_regs[d][15:0] = v[15:0];
            default:       model_regs[d] = v;
        endcase
    endtask

    // x86 semantics for the eight ops, updating the expected flags
    task automatic model_exec(input alu_op_t o, input word_t a, input word_t b,
                              output word_t res, output logic writes);
        flags_t      f;
        logic [32:0] wide;
        logic [7:0]  low;
        logic        lo_adj;
        logic        hi_adj;
        f      = model_flags;
        res    = '0;
        writes = 1'b1;
        case (o)
            `OP_ADD: begin
                wide        = {1'b0, a} + {1'b0, b};
                res         = wide[31:0];
                f[`FLAG_CF] = wide[32];
                f[`FLAG_AF] = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
                f[`FLAG_OF] = (a[31] == b[31]) && (res[31] != a[31]);
            end
            `OP_SUB: begin
                // b minus a, the carry of b + ~a + 1 means no borrow
                res         = b - a;
                f[`FLAG_CF] = (b >= a);
                f[`FLAG_AF] = (b[3:0] >= a[3:0]);
                f[`FLAG_OF] = (a[31] != b[31]) && (res[31] != b[31]);
            end
            `OP_OR, `OP_AND: begin
                res         = (o == `OP_OR) ? (a | b) : (a & b);
                f[`FLAG_CF] = 1'b0;
                f[`FLAG_OF] = 1'b0;
            end
            `OP_NOT: res = ~a;
            `OP_DAA: begin
                lo_adj = (a[3:0] > 4'd9) || f[`FLAG_AF];
                hi_adj = (a[7:0] > 8'h99) || f[`FLAG_CF];
                low    = a[7:0];
                if (lo_adj) begin
                    low = low + 8'h06;
                end
                if (hi_adj) begin
                    low = low + 8'h60;
                end
                f[`FLAG_AF] = lo_adj;
                f[`FLAG_CF] = hi_adj;
                res         = {a[31:8], low};
            end
            default: begin
                // cld and std only move DF
                f[`FLAG_DF] = (o == `OP_STD);
                writes      = 1'b0;
            end
        endcase
        if (writes && (o != `OP_NOT)) begin
            f[`FLAG_ZF] = (res == 32'h0);
            f[`FLAG_SF] = res[31];
            f[`FLAG_PF] = ~^res[7:0];
        end
        model_flags = f;
    endtask

    task automatic drive_load(input gpr_idx_t d, input access_size_t size, input word_t v);
        load      = 1'b1;
        load_dst  = d;
        load_size = size;
        load_data = v;
    endtask

    task automatic drive_exec(input alu_op_t o, input gpr_idx_t sa, input access_size_t za,
                              input gpr_idx_t sb, input access_size_t zb,
                              input gpr_idx_t d, input access_size_t dz);
        exec     = 1'b1;
        op       = o;
        src_a    = sa;
        size_a   = za;
        src_b    = sb;
        size_b   = zb;
        dst      = d;
        dst_size = dz;
    endtask

    // the model applies the load first so that an ALU write to the same lane wins
    task automatic apply_cycle();
        word_t a_val;
        word_t b_val;
        word_t res;
        logic  writes;
        a_val  = model_read(src_a, size_a);
        b_val  = model_read(src_b, size_b);
        res    = '0;
        writes = 1'b0;
        if (exec) begin
            model_exec(op, a_val, b_val, res, writes);
        end
        if (load) begin
            model_write(load_dst, load_size, load_data);
        end
        if (writes) begin
            model_write(dst, dst_size, res);
        end
        wait_falling_edges(1);
        load = 1'b0;
        exec = 1'b0;
    endtask

    task automatic observe_reg(input gpr_idx_t sel, input access_size_t size);
        obs_sel  = sel;
        obs_size = size;
        wait_falling_edges(1);
        check_word(obs_data, model_read(sel, size), $sformatf("reg %0d size %0d", sel, size));
        check_flags(flags, model_flags);
    endtask

    task automatic observe_all(input gpr_idx_t sel);
        for (int s = 0; s < 4; s++) begin
            observe_reg(sel, access_size_t'(s));
        end
    endtask

    // operands go to registers 4 and 5, the result to register 6
    task automatic run_alu(input alu_op_t o, input word_t a_val, input word_t b_val);
        drive_load(3'd4, `SIZE_WORD, a_val);
        apply_cycle();
        drive_load(3'd5, `SIZE_WORD, b_val);
        apply_cycle();
        drive_exec(o, 3'd4, `SIZE_WORD, 3'd5, `SIZE_WORD, 3'd6, `SIZE_WORD);
        apply_cycle();
        observe_reg(3'd6, `SIZE_WORD);
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%s: %s", name, (errors == errors_before) ? "passed" : "failed");
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        for (int r = 0; r < `GPR_COUNT; r++) begin
            observe_all(gpr_idx_t'(r));
        end
        report_test("reset", start);
    endtask

    task automatic test_load_sizes();
        int start;
        start = errors;
        drive_load(3'd1, `SIZE_WORD, 32'h1122_3344);
        apply_cycle();
        observe_all(3'd1);
        drive_load(3'd1, `SIZE_BYTE_LO, 32'hFFFF_FFAB);
        apply_cycle();
        observe_all(3'd1);
        // upper data bits must not leak into lane lh
        drive_load(3'd1, `SIZE_BYTE_HI, 32'hEEEE_EECD);
        apply_cycle();
        observe_all(3'd1);
        drive_load(3'd1, `SIZE_HALF, 32'hDDDD_5566);
        apply_cycle();
        observe_all(3'd1);
        drive_load(3'd2, `SIZE_BYTE_HI, 32'h0000_0077);
        apply_cycle();
        observe_all(3'd2);
        observe_all(3'd1);
        report_test("load sizes", start);
    endtask

    task automatic test_add_sub();
        int start;
        start = errors;
        run_alu(`OP_ADD, 32'hFFFF_FFFF, 32'h0000_0001);
        run_alu(`OP_ADD, 32'h7FFF_FFFF, 32'h0000_0001);
        run_alu(`OP_ADD, 32'h0000_000F, 32'h0000_0001);
        run_alu(`OP_ADD, 32'h8000_0000, 32'h8000_0000);
        run_alu(`OP_SUB, 32'h0000_0005, 32'h0000_0003);
        run_alu(`OP_SUB, 32'h0000_0003, 32'h0000_0005);
        run_alu(`OP_SUB, 32'hFFFF_FFFF, 32'h7FFF_FFFF);
        run_alu(`OP_SUB, 32'h1234_5678, 32'h1234_5678);
        report_test("add and sub", start);
    endtask

    task automatic test_logic();
        int start;
        start = errors;
        // or and the first and each follow an add that leaves OF and CF set
        run_alu(`OP_ADD, 32'h8000_0000, 32'h8000_0000);
        run_alu(`OP_OR, 32'hF0F0_0000, 32'h0000_0F0F);
        run_alu(`OP_ADD, 32'h8000_0000, 32'h8000_0001);
        run_alu(`OP_AND, 32'hFF00_FF00, 32'h0FF0_0FF0);
        run_alu(`OP_AND, 32'hFF00_0000, 32'h00FF_0000);
        run_alu(`OP_ADD, 32'h8000_0000, 32'h8000_0001);
        run_alu(`OP_NOT, 32'h1234_5678, 32'h0);
        // register 6 must keep the not result through std and cld
        drive_exec(`OP_STD, 3'd4, `SIZE_WORD, 3'd5, `SIZE_WORD, 3'd6, `SIZE_WORD);
        apply_cycle();
        observe_reg(3'd6, `SIZE_WORD);
        drive_exec(`OP_CLD, 3'd4, `SIZE_WORD, 3'd5, `SIZE_WORD, 3'd6, `SIZE_WORD);
        apply_cycle();
        observe_reg(3'd6, `SIZE_WORD);
        report_test("logic and direction", start);
    endtask

    // the add before daa sets up the old AF and CF
    task automatic run_daa(input word_t value, input word_t pre_a, input word_t pre_b);
        run_alu(`OP_ADD, pre_a, pre_b);
        drive_load(3'd3, `SIZE_WORD, value);
        apply_cycle();
        drive_exec(`OP_DAA, 3'd3, `SIZE_BYTE_LO, 3'd5, `SIZE_WORD, 3'd3, `SIZE_BYTE_LO);
        apply_cycle();
        observe_reg(3'd3, `SIZE_WORD);
    endtask

    task automatic test_daa();
        int start;
        start = errors;
        run_daa(32'hAB00_0009, 32'h1, 32'h1);
        run_daa(32'h0000_000A, 32'h1, 32'h1);
        run_daa(32'h0000_009A, 32'h1, 32'h1);
        run_daa(32'h0000_0012, 32'h9, 32'h9);
        run_daa(32'h0000_0012, 32'h8000_0000, 32'h8000_0000);
        run_daa(32'h0000_0045, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        report_test("daa", start);
    endtask

    task automatic test_collision();
        int start;
        start = errors;
        run_alu(`OP_ADD, 32'h0000_0011, 32'h0000_0022);
        // the load owns lane lh, both ports hit lane ll
        drive_load(3'd2, `SIZE_HALF, 32'h0000_AAAA);
        drive_exec(`OP_ADD, 3'd4, `SIZE_BYTE_LO, 3'd5, `SIZE_BYTE_LO, 3'd2, `SIZE_BYTE_LO);
        apply_cycle();
        observe_all(3'd2);
        drive_load(3'd2, `SIZE_WORD, 32'h1234_5678);
        drive_exec(`OP_OR, 3'd4, `SIZE_WORD, 3'd5, `SIZE_WORD, 3'd2, `SIZE_WORD);
        apply_cycle();
        observe_reg(3'd2, `SIZE_WORD);
        report_test("load and exec collision", start);
    endtask

    task automatic test_random();
        int          start;
        logic [31:0] rnd;
        start = errors;
        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            if (rnd[0]) begin
                drive_load(rnd[3:1], rnd[5:4], $random(seed));
            end
            if (rnd[6] || !rnd[0]) begin
                drive_exec(rnd[9:7], rnd[12:10], rnd[14:13], rnd[17:15], rnd[19:18],
                           rnd[22:20], rnd[24:23]);
            end
            apply_cycle();
            observe_reg(rnd[27:25], rnd[29:28]);
        end
        report_test("random ops", start);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        load      = 1'b0;
        load_dst  = '0;
        load_size = '0;
        load_data = '0;
        exec      = 1'b0;
        op        = '0;
        src_a     = '0;
        size_a    = '0;
        src_b     = '0;
        size_b    = '0;
        dst       = '0;
        dst_size  = '0;
        obs_sel   = '0;
        obs_size  = '0;
        errors    = 0;
        seed      = 58212;
        model_flags = '0;
        for (int r = 0; r < `GPR_COUNT; r++) begin
            model_regs[r] = '0;
        end
        wait_falling_edges(3);
        rst_n = 1'b1;
        test_reset();
        test_load_sizes();
        test_add_sub();
        test_logic();
        test_daa();
        test_collision();
        test_random();
        $display("tests run: 7, errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/gpr_pkg.sv
design/alu_pkg.sv
design/gpr_write_port.sv
design/gpr_bank.sv
design/gpr_read_port.sv
design/alu32.sv
design/flags_reg.sv
design/gpr_alu_datapath.sv
bench/gpr_alu_checker.sv
bench/gpr_alu_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module gpr_alu_tb -f filelist.f

sim:
	verilator --binary --timing --assert --top-module gpr_alu_tb -f filelist.f -o gpr_alu_sim
	./obj_dir/gpr_alu_sim | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
